// ==== layer_norm_top.f ====
+incdir+.
ln_fixed_pkg.sv
ln_ctrl_pkg.sv
ln_stream_reg.sv
ln_coef_store.sv
ln_stats.sv
ln_inv_std.sv
ln_affine.sv
layer_norm_top.sv
tb_layer_norm.sv

// ==== Bender.yml ====
package:
  name: layer_norm

export_include_dirs:
  - .

sources:
  - ln_fixed_pkg.sv
  - ln_ctrl_pkg.sv
  - ln_stream_reg.sv
  - ln_coef_store.sv
  - ln_stats.sv
  - ln_inv_std.sv
  - ln_affine.sv
  - layer_norm_top.sv
  - target: test
    files:
      - tb_layer_norm.sv

// ==== tb_layer_norm.sv ====
`timescale 1ns/1ps
`include "ln_config.svh"

module tb_layer_norm;

    import ln_fixed_pkg::*;

    localparam int W          = `LN_WIDTH;
    localparam int F          = `LN_FRAC;
    localparam int DEPTH_LOG  = $clog2(`LN_DEPTH);
    localparam int INV_MAX    = 2 ** (W + 1) - 1;
    localparam int ELEM_MAX   = 2 ** (W - 1) - 1;
    localparam int ELEM_MIN   = -(2 ** (W - 1));
    localparam int N_VECTORS  = 68;
    localparam int WATCHDOG_CYCLES = N_VECTORS * (3 * W + 8) + 2000;

    logic clk = 1'b0;
    logic rst_n;
    vec_t data_in;
    logic data_in_valid;
    logic data_in_ready;
    vec_t gamma;
    logic gamma_valid;
    logic gamma_ready;
    vec_t beta;
    logic beta_valid;
    logic beta_ready;
    vec_t data_out;
    logic data_out_valid;
    logic data_out_ready;

    // model coefficients and scoreboard memory
    vec_t cur_gamma;
    vec_t cur_beta;
    vec_t exp_mem [0:127];
    int   wr_ptr = 0;
    int   rd_ptr = 0;
    vec_t exp_head;
    logic exp_empty;
    logic got_gamma = 1'b0;
    logic got_beta = 1'b0;

    logic [31:0] rng_data = 32'hc0e9_38ed;
    logic [31:0] rng_bp = 32'hc0e9_38ed ^ 32'h5a5a_a5a5;
    logic bp_on = 1'b0;
    int   fail_count = 0;
    int   fails_at_start = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;

    layer_norm_top dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .data_in        (data_in),
        .data_in_valid  (data_in_valid),
        .data_in_ready  (data_in_ready),
        .gamma          (gamma),
        .gamma_valid    (gamma_valid),
        .gamma_ready    (gamma_ready),
        .beta           (beta),
        .beta_valid     (beta_valid),
        .beta_ready     (beta_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

    // 100 ns period
    always
    begin
        #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic vec_t rand_vec();
        vec_t v;
        for (int i = 0; i < `LN_DEPTH; i++)
        begin
            rng_data = xorshift(rng_data);
            v[i] = rng_data[W-1:0];
        end
        return v;
    endfunction

    // straight from the arithmetic rule, all in plain ints
    function automatic vec_t ref_norm(input vec_t x, input vec_t g, input vec_t b);
        vec_t y;
        int   sum;
        int   sq;
        int   mean;
        int   variance;
        int   s;
        int   inv;
        int   t;
        sum = 0;
        sq  = 0;
        for (int i = 0; i < `LN_DEPTH; i++)
        begin
            sum = sum + int'(x[i]);
            sq  = sq + int'(x[i]) * int'(x[i]);
        end
        mean     = sum >>> DEPTH_LOG;
        variance = (sq >>> DEPTH_LOG) - mean * mean;
        if (variance < 0)
            variance = 0;
        variance = variance + `LN_EPS;
        // floor square root by search, small range
        s = 0;
        while ((s + 1) * (s + 1) <= variance)
            s++;
        inv = (s == 0) ? INV_MAX : (1 << (2 * F)) / s;
        if (inv > INV_MAX)
            inv = INV_MAX;
        for (int i = 0; i < `LN_DEPTH; i++)
        begin
            t = ((int'(x[i]) - mean) * inv) >>> F;
            t = (t * int'(g[i])) >>> F;
            t = t + int'(b[i]);
            if (t > ELEM_MAX)
                t = ELEM_MAX;
            else if (t < ELEM_MIN)
                t = ELEM_MIN;
            y[i] = elem_t'(t);
        end
        return y;
    endfunction

    // scoreboard, push on input transfer, pop on output transfer
    assign exp_head  = exp_mem[rd_ptr];
    assign exp_empty = (rd_ptr == wr_ptr);

    always @(posedge clk)
    begin
        if (rst_n && data_in_valid && data_in_ready)
        begin
            exp_mem[wr_ptr] <= ref_norm(data_in, cur_gamma, cur_beta);
            wr_ptr <= wr_ptr + 1;
        end
        if (rst_n && data_out_valid && data_out_ready && !exp_empty)
            rd_ptr <= rd_ptr + 1;
        if (rst_n && gamma_valid && gamma_ready)
            got_gamma <= 1'b1;
        if (rst_n && beta_valid && beta_ready)
            got_beta <= 1'b1;
    end

    // random stalls on the output only while bp_on
    always @(posedge clk)
    begin
        #1;
        if (bp_on)
        begin
            rng_bp = xorshift(rng_bp);
            data_out_ready = rng_bp[3];
        end
        else
            data_out_ready = 1'b1;
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !data_out_valid)
    else
    begin
        $display("CHECK FAILED at %0t: data_out_valid high during reset", $time);
        fail_count++;
    end

    a_no_early: assert property (@(posedge clk) disable iff (!rst_n)
        data_out_valid |-> (got_gamma && got_beta))
    else
    begin
        $display("CHECK FAILED at %0t: output before gamma and beta loaded", $time);
        fail_count++;
    end

    a_expected: assert property (@(posedge clk) disable iff (!rst_n)
        data_out_valid |-> !exp_empty)
    else
    begin
        $display("CHECK FAILED at %0t: output with no vector outstanding", $time);
        fail_count++;
    end

    a_match: assert property (@(posedge clk) disable iff (!rst_n)
        (data_out_valid && data_out_ready && !exp_empty) |-> data_out == exp_head)
    else
    begin
        $display("CHECK FAILED at %0t: data_out %h, expected %h", $time,
                 $sampled(data_out), $sampled(exp_head));
        fail_count++;
    end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (data_out_valid && !data_out_ready) |=> (data_out_valid && $stable(data_out)))
    else
    begin
        $display("CHECK FAILED at %0t: output dropped or changed while stalled", $time);
        fail_count++;
    end

    // coefficient ports open from the first cycle after reset
    a_coef_ready: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (gamma_ready && beta_ready))
    else
    begin
        $display("CHECK FAILED at %0t: gamma_ready or beta_ready low after reset", $time);
        fail_count++;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic send_vec(input vec_t v);
        data_in       = v;
        data_in_valid = 1'b1;
        while (!data_in_ready)
            tick();
        tick();
        data_in_valid = 1'b0;
    endtask

    task automatic load_coefs(input vec_t g, input vec_t b);
        cur_gamma   = g;
        cur_beta    = b;
        gamma       = g;
        beta        = b;
        gamma_valid = 1'b1;
        beta_valid  = 1'b1;
        while (!(gamma_ready && beta_ready))
            tick();
        tick();
        gamma_valid = 1'b0;
        beta_valid  = 1'b0;
    endtask

    // every pushed vector has come out
    task automatic wait_drain();
        while (!exp_empty)
            tick();
        tick();
    endtask

    task automatic end_test(input string name);
        if (fail_count == fails_at_start)
        begin
            tests_passed++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d check(s) failed", name, fail_count - fails_at_start);
        end
        fails_at_start = fail_count;
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT appears to hang", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        vec_t v;
        vec_t g;
        vec_t b;
        rst_n          = 1'b0;
        data_in        = '0;
        data_in_valid  = 1'b0;
        gamma          = '0;
        gamma_valid    = 1'b0;
        beta           = '0;
        beta_valid     = 1'b0;
        data_out_ready = 1'b1;
        cur_gamma      = '0;
        cur_beta       = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // vectors sent before any coefficients must wait
        cur_gamma = rand_vec();
        cur_beta  = rand_vec();
        g = cur_gamma;
        b = cur_beta;
        send_vec(rand_vec());
        send_vec(rand_vec());
        repeat (3 * W + 3 + 8) tick();
        load_coefs(g, b);
        wait_drain();
        end_test("no output before coefficients");

        for (int n = 0; n < 20; n++)
            send_vec(rand_vec());
        wait_drain();
        end_test("random vectors");

        // constant input, variance is epsilon only
        for (int n = 0; n < 6; n++)
        begin
            rng_data = xorshift(rng_data);
            for (int i = 0; i < `LN_DEPTH; i++)
                v[i] = rng_data[W-1:0];
            send_vec(v);
        end
        wait_drain();
        end_test("constant vectors");

        // full-scale alternating signs, large gamma
        for (int i = 0; i < `LN_DEPTH; i++)
        begin
            g[i] = elem_t'(ELEM_MAX);
            b[i] = (i % 2 == 0) ? elem_t'(ELEM_MAX) : elem_t'(ELEM_MIN);
        end
        load_coefs(g, b);
        for (int n = 0; n < 4; n++)
        begin
            for (int i = 0; i < `LN_DEPTH; i++)
                v[i] = ((i + n) % 2 == 0) ? elem_t'(ELEM_MAX) : elem_t'(ELEM_MIN);
            send_vec(v);
        end
        wait_drain();
        end_test("saturation");

        load_coefs(rand_vec(), rand_vec());
        bp_on = 1'b1;
        for (int n = 0; n < 20; n++)
            send_vec(rand_vec());
        wait_drain();
        bp_on = 1'b0;
        tick();
        end_test("output back-pressure");

        // reload between batches once the pipe is empty
        for (int k = 0; k < 2; k++)
        begin
            load_coefs(rand_vec(), rand_vec());
            for (int n = 0; n < 8; n++)
                send_vec(rand_vec());
            wait_drain();
        end
        end_test("coefficient reload");

        $display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
                 tests_passed, tests_failed, fail_count);
        if (fail_count == 0 && tests_failed == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== layer_norm_top.sv ====
`timescale 1ns/1ps
`include "ln_config.svh"

module layer_norm_top (
    input  logic               clk,
    input  logic               rst_n,
    input  ln_fixed_pkg::vec_t data_in,
    input  logic               data_in_valid,
    output logic               data_in_ready,
    input  ln_fixed_pkg::vec_t gamma,
    input  logic               gamma_valid,
    output logic               gamma_ready,
    input  ln_fixed_pkg::vec_t beta,
    input  logic               beta_valid,
    output logic               beta_ready,
    output ln_fixed_pkg::vec_t data_out,
    output logic               data_out_valid,
    input  logic               data_out_ready
);

    import ln_fixed_pkg::*;

    localparam int N_OUT = `LN_OUT_STAGES;

    // stats front end, before and after its slice
    stats_t stats_c;
    logic   stats_c_valid;
    logic   stats_c_ready;
    stats_t stats_r;
    logic   stats_r_valid;
    logic   stats_r_ready;

    // inverse deviation result
    norm_t  norm;
    logic   norm_valid;
    logic   norm_ready;

    vec_t   coef_gamma;
    vec_t   coef_beta;
    logic   coef_loaded;

    // output slice chain, index 0 is the affine result
    vec_t   out_data  [0:N_OUT];
    logic   out_valid [0:N_OUT];
    logic   out_ready [0:N_OUT];

    ln_coef_store u_coef (
        .clk         (clk),
        .rst_n       (rst_n),
        .gamma       (gamma),
        .gamma_valid (gamma_valid),
        .gamma_ready (gamma_ready),
        .beta        (beta),
        .beta_valid  (beta_valid),
        .beta_ready  (beta_ready),
        .coef_gamma  (coef_gamma),
        .coef_beta   (coef_beta),
        .coef_loaded (coef_loaded)
    );

    ln_stats u_stats (
        .data_in       (data_in),
        .data_in_valid (data_in_valid),
        .data_in_ready (data_in_ready),
        .stats         (stats_c),
        .stats_valid   (stats_c_valid),
        .stats_ready   (stats_c_ready)
    );

    // holds a second vector while the sequencer is busy
    ln_stream_reg #(.payload_t(stats_t)) u_stats_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (stats_c),
        .in_valid  (stats_c_valid),
        .in_ready  (stats_c_ready),
        .out_data  (stats_r),
        .out_valid (stats_r_valid),
        .out_ready (stats_r_ready)
    );

    ln_inv_std u_inv_std (
        .clk         (clk),
        .rst_n       (rst_n),
        .stats       (stats_r),
        .stats_valid (stats_r_valid),
        .stats_ready (stats_r_ready),
        .norm        (norm),
        .norm_valid  (norm_valid),
        .norm_ready  (norm_ready)
    );

    ln_affine u_affine (
        .norm        (norm),
        .norm_valid  (norm_valid),
        .norm_ready  (norm_ready),
        .coef_gamma  (coef_gamma),
        .coef_beta   (coef_beta),
        .coef_loaded (coef_loaded),
        .y           (out_data[0]),
        .y_valid     (out_valid[0]),
        .y_ready     (out_ready[0])
    );

    for (genvar s = 0; s < N_OUT; s++)
    begin : g_out
        ln_stream_reg #(.payload_t(vec_t)) u_out_reg (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_data   (out_data[s]),
            .in_valid  (out_valid[s]),
            .in_ready  (out_ready[s]),
            .out_data  (out_data[s+1]),
            .out_valid (out_valid[s+1]),
            .out_ready (out_ready[s+1])
        );
    end

    assign data_out         = out_data[N_OUT];
    assign data_out_valid   = out_valid[N_OUT];
    assign out_ready[N_OUT] = data_out_ready;

endmodule

// ==== ln_affine.sv ====
`timescale 1ns/1ps
`include "ln_config.svh"

module ln_affine (
    input  ln_fixed_pkg::norm_t norm,
    input  logic                norm_valid,
    output logic                norm_ready,
    input  ln_fixed_pkg::vec_t  coef_gamma,
    input  ln_fixed_pkg::vec_t  coef_beta,
    input  logic                coef_loaded,
    output ln_fixed_pkg::vec_t  y,
    output logic                y_valid,
    input  logic                y_ready
);

    import ln_fixed_pkg::*;

    localparam int W        = `LN_WIDTH;
    localparam int F        = `LN_FRAC;
    localparam int PROD_W   = 2 * W + 3;
    localparam int GAIN_W   = PROD_W + W;
    localparam int ELEM_MAX = 2 ** (W - 1) - 1;
    localparam int ELEM_MIN = -(2 ** (W - 1));

    logic signed [W:0]        centred;
    logic signed [PROD_W-1:0] scaled;
    logic signed [GAIN_W-1:0] gained;
    logic signed [GAIN_W:0]   biased;

    // stream stalls here until gamma and beta are in
    assign y_valid    = norm_valid && coef_loaded;
    assign norm_ready = y_ready && coef_loaded;

    always_comb
    begin
        for (int i = 0; i < `LN_DEPTH; i++)
        begin
            centred = norm.vec[i] - norm.mean;
            // inv is unsigned, zero-extend before the signed multiply
            scaled  = centred * $signed({1'b0, norm.inv});
            scaled  = scaled >>> F;
            gained  = scaled * coef_gamma[i];
            gained  = gained >>> F;
            biased  = gained + coef_beta[i];

            // clip to the element range
            if (biased > ELEM_MAX)
                y[i] = elem_t'(ELEM_MAX);
            else if (biased < ELEM_MIN)
                y[i] = elem_t'(ELEM_MIN);
            else
                y[i] = biased[W-1:0];
        end
    end

endmodule

// ==== ln_inv_std.sv ====
`timescale 1ns/1ps
`include "ln_config.svh"

module ln_inv_std (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ln_fixed_pkg::stats_t stats,
    input  logic                 stats_valid,
    output logic                 stats_ready,
    output ln_fixed_pkg::norm_t  norm,
    output logic                 norm_valid,
    input  logic                 norm_ready
);

    import ln_fixed_pkg::*;
    import ln_ctrl_pkg::*;

    localparam int W     = `LN_WIDTH;
    localparam int CNT_W = $clog2(2 * W + 1);

    // numerator of the reciprocal, 1.0 at 2*LN_FRAC fraction bits
    localparam logic [2*W-1:0] RECIP_NUM = (2 * W)'(1) << (2 * `LN_FRAC);
    localparam inv_t           INV_MAX   = '1;

    inv_state_t       state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             accept;

    // square root registers
    logic [2*W-1:0]   rad_q;
    logic [W:0]       srem_q;
    logic [W-1:0]     root_q;

    // divider registers
    logic [W-1:0]     drem_q;
    logic [2*W-1:0]   quo_q;

    // payload riding along with the computation
    vec_t             vec_q;
    elem_t            mean_q;
    inv_t             inv_q;

    logic [W+2:0]     srem_sh;
    logic [W+2:0]     strial;
    logic             sqrt_take;
    logic [W:0]       drem_sh;
    logic             div_take;
    inv_t             inv_sat;

    assign stats_ready = state_q == IDLE;
    assign accept      = stats_valid && stats_ready;
    assign norm_valid  = state_q == DONE;

    assign norm.vec  = vec_q;
    assign norm.mean = mean_q;
    assign norm.inv  = inv_q;

    always_comb
    begin
        // restoring sqrt, two radicand bits per step
        srem_sh   = {srem_q, rad_q[2*W-1 -: 2]};
        strial    = {1'b0, root_q, 2'b01};
        sqrt_take = srem_sh >= strial;

        // restoring division, one quotient bit per step
        drem_sh   = {drem_q, quo_q[2*W-1]};
        div_take  = drem_sh >= {1'b0, root_q};

        // zero root gives an all-ones quotient, lands on max here too
        if (|quo_q[2*W-1:W+1])
            inv_sat = INV_MAX;
        else
            inv_sat = quo_q[W:0];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end
        else
        begin
            case (state_q)
                IDLE:
                begin
                    cnt_q <= '0;
                    if (accept)
                        state_q <= SQRT;
                end
                SQRT:
                begin
                    // W steps
                    if (cnt_q == CNT_W'(W - 1))
                    begin
                        state_q <= RECIP;
                        cnt_q   <= '0;
                    end
                    else
                        cnt_q <= cnt_q + 1'b1;
                end
                RECIP:
                begin
                    // 2W steps, then one cycle to saturate into inv_q
                    if (cnt_q == CNT_W'(2 * W))
                        state_q <= DONE;
                    else
                        cnt_q <= cnt_q + 1'b1;
                end
                default:
                begin
                    if (norm_ready)
                        state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            vec_q  <= stats.vec;
            mean_q <= stats.mean;
            rad_q  <= stats.variance;
            srem_q <= '0;
            root_q <= '0;
            drem_q <= '0;
            quo_q  <= RECIP_NUM;
        end
        else if (state_q == SQRT)
        begin
            srem_q <= sqrt_take ? (W + 1)'(srem_sh - strial) : srem_sh[W:0];
            root_q <= {root_q[W-2:0], sqrt_take};
            rad_q  <= rad_q << 2;
        end
        else if (state_q == RECIP)
        begin
            if (cnt_q == CNT_W'(2 * W))
                inv_q <= inv_sat;
            else
            begin
                drem_q <= div_take ? W'(drem_sh - {1'b0, root_q}) : drem_sh[W-1:0];
                quo_q  <= {quo_q[2*W-2:0], div_take};
            end
        end
    end

endmodule

// ==== ln_stats.sv ====
`timescale 1ns/1ps
`include "ln_config.svh"

module ln_stats (
    input  ln_fixed_pkg::vec_t   data_in,
    input  logic                 data_in_valid,
    output logic                 data_in_ready,
    output ln_fixed_pkg::stats_t stats,
    output logic                 stats_valid,
    input  logic                 stats_ready
);

    import ln_fixed_pkg::*;

    localparam int W         = `LN_WIDTH;
    localparam int DEPTH_LOG = $clog2(`LN_DEPTH);

    sum_t                    sum;
    sq_sum_t                 sq_sum;
    logic signed [2*W-1:0]   sq;
    sum_t                    mean_wide;
    elem_t                   mean;
    logic        [2*W-1:0]   mean_sq;
    sq_sum_t                 ex2_wide;
    logic signed [2*W+1:0]   diff;
    var_t                    variance;

    // no storage here, the handshake just passes through
    assign stats_valid   = data_in_valid;
    assign data_in_ready = stats_ready;

    always_comb
    begin
        sum    = '0;
        sq_sum = '0;
        for (int i = 0; i < `LN_DEPTH; i++)
        begin
            sum    = sum + sum_t'(data_in[i]);
            // square of a signed element, never negative
            sq     = data_in[i] * data_in[i];
            sq_sum = sq_sum + sq_sum_t'($unsigned(sq));
        end

        // floor of the mean, arithmetic shift
        mean_wide = sum >>> DEPTH_LOG;
        mean      = mean_wide[W-1:0];
        // full 2W-bit square, never negative
        mean_sq   = mean * mean;

        // E[x^2] - mean^2
        ex2_wide  = sq_sum >> DEPTH_LOG;
        diff      = $signed({2'b00, ex2_wide[2*W-1:0]}) - $signed({2'b00, mean_sq});

        // floored mean can push the difference below zero
        if (diff < 0)
            variance = var_t'(`LN_EPS);
        else
            variance = diff[2*W-1:0] + var_t'(`LN_EPS);
    end

    assign stats.vec      = data_in;
    assign stats.mean     = mean;
    assign stats.variance = variance;

endmodule

// ==== ln_coef_store.sv ====
`timescale 1ns/1ps

module ln_coef_store (
    input  logic               clk,
    input  logic               rst_n,
    input  ln_fixed_pkg::vec_t gamma,
    input  logic               gamma_valid,
    output logic               gamma_ready,
    input  ln_fixed_pkg::vec_t beta,
    input  logic               beta_valid,
    output logic               beta_ready,
    output ln_fixed_pkg::vec_t coef_gamma,
    output ln_fixed_pkg::vec_t coef_beta,
    output logic               coef_loaded
);

    import ln_fixed_pkg::*;
    import ln_ctrl_pkg::*;

    coef_state_t state_q;
    logic        ready_q;
    logic        have_gamma_q;
    logic        gamma_fire;
    logic        beta_fire;
    vec_t        gamma_q;
    vec_t        beta_q;

    // both ports open once reset is released and stay open
    assign gamma_ready = ready_q;
    assign beta_ready  = ready_q;
    assign gamma_fire  = gamma_valid && ready_q;
    assign beta_fire   = beta_valid && ready_q;

    assign coef_gamma  = gamma_q;
    assign coef_beta   = beta_q;
    assign coef_loaded = state_q == LOADED;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ready_q      <= 1'b0;
            state_q      <= EMPTY;
            have_gamma_q <= 1'b0;
        end
        else
        begin
            ready_q <= 1'b1;
            case (state_q)
                EMPTY:
                begin
                    // both in one cycle skips PARTIAL
                    if (gamma_fire && beta_fire)
                        state_q <= LOADED;
                    else if (gamma_fire || beta_fire)
                        state_q <= PARTIAL;
                    have_gamma_q <= gamma_fire;
                end
                PARTIAL:
                begin
                    // waiting on whichever one is still missing
                    if ((gamma_fire && !have_gamma_q) || (beta_fire && have_gamma_q))
                        state_q <= LOADED;
                end
                // reloads just overwrite the vectors
                default: state_q <= LOADED;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (gamma_fire)
            gamma_q <= gamma;
        if (beta_fire)
            beta_q <= beta;
    end

endmodule

// ==== ln_stream_reg.sv ====
`timescale 1ns/1ps

module ln_stream_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    logic     valid_q;
    payload_t data_q;

    // free slot, or the held entry leaves this cycle
    assign in_ready  = !valid_q || out_ready;
    assign out_valid = valid_q;
    assign out_data  = data_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q <= 1'b0;
        end
        else if (in_valid && in_ready)
        begin
            valid_q <= 1'b1;
        end
        else if (out_ready)
        begin
            valid_q <= 1'b0;
        end
    end

    // payload only, loaded on each accepted transfer
    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            data_q <= in_data;
        end
    end

endmodule

// ==== ln_ctrl_pkg.sv ====
package ln_ctrl_pkg;

    // inverse deviation sequencer
    // IDLE accepts, SQRT and RECIP iterate, DONE holds the result
    typedef enum logic [1:0] {
        IDLE,
        SQRT,
        RECIP,
        DONE
    } inv_state_t;

    // coefficient store
    // PARTIAL means only one of gamma/beta has arrived so far
    typedef enum logic [1:0] {
        EMPTY,
        PARTIAL,
        LOADED
    } coef_state_t;

endpackage

// ==== ln_fixed_pkg.sv ====
`include "ln_config.svh"

package ln_fixed_pkg;

    // one signed fixed-point element
    typedef logic signed [`LN_WIDTH-1:0] elem_t;

    // whole vector, element 0 in the low bits
    typedef elem_t [`LN_DEPTH-1:0] vec_t;

    // sum of elements, widened by log2 of the depth
    typedef logic signed [`LN_WIDTH+$clog2(`LN_DEPTH)-1:0] sum_t;

    // sum of squares, always non-negative
    typedef logic [2*`LN_WIDTH+$clog2(`LN_DEPTH)-1:0] sq_sum_t;

    // variance incl. epsilon, 2*LN_FRAC fraction bits
    typedef logic [2*`LN_WIDTH-1:0] var_t;

    // inverse deviation, unsigned, LN_FRAC fraction bits
    // one extra bit so 1.0/small roots still fit
    typedef logic [`LN_WIDTH:0] inv_t;

    // stats front end -> inverse deviation unit
    typedef struct packed {
        vec_t  vec;
        elem_t mean;
        var_t  variance;
    } stats_t;

    // inverse deviation unit -> affine back end
    typedef struct packed {
        vec_t  vec;
        elem_t mean;
        inv_t  inv;
    } norm_t;

endpackage

// ==== ln_config.svh ====
`ifndef LN_CONFIG_SVH
`define LN_CONFIG_SVH

// element width in bits, signed
`define LN_WIDTH 8

// fraction bits shared by elements, gamma, beta and the inverse deviation
`define LN_FRAC 4

// elements per vector
// power of two only, the mean is a plain shift
`define LN_DEPTH 8

// epsilon added to the variance
// in variance units, so 2*LN_FRAC fraction bits
`define LN_EPS 1

// register slices between the affine stage and data_out
// each one adds a cycle of latency
`define LN_OUT_STAGES 1

`endif
